/* logic/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data, address and instruction width
`define WORD_SIZE    16

// Register file geometry
`define REG_SEL      2
`define NUM_REGS     4

// Instruction fields
`define OPCODE_FIELD 15:12
`define RS_FIELD     11:10
`define RT_FIELD     9:8
`define RD_FIELD     7:6
`define IMM8_FIELD   7:0
`define IMM8_BITS    8
`define IMM12_FIELD  11:0
`define IMM12_BITS   12

`endif

/* logic/isa_pkg.sv */
package isa_pkg;

    // Primary opcode, top nibble of every instruction
    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_ADI = 4'h2,
        OP_LWD = 4'h3,
        OP_SWD = 4'h4,
        OP_BNE = 4'h5,
        OP_JMP = 4'h6,
        OP_WWD = 4'h7,
        OP_HLT = 4'h8,
        // Bubble that flushed slots turn into
        OP_NOP = 4'hF
    } opcode_t;

    // ALU operations
    typedef enum logic [1:0] {
        ALU_ADD    = 2'b00,
        ALU_SUB    = 2'b01,
        ALU_PASS_B = 2'b10
    } alu_op_t;

endpackage

/* logic/pipe_pkg.sv */
package pipe_pkg;

    // Pipeline control FSM
    typedef enum logic [1:0] {
        ST_RUN   = 2'b00,
        ST_STALL = 2'b01,
        ST_HALT  = 2'b10
    } ctrl_state_t;

    // EX operand source
    typedef enum logic {
        FWD_REG = 1'b0,
        FWD_MW  = 1'b1
    } fwd_sel_t;

endpackage

/* logic/register_file.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module register_file (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [`REG_SEL-1:0]   read1,
    input  logic [`REG_SEL-1:0]   read2,
    input  logic                  write_en,
    input  logic [`REG_SEL-1:0]   dest,
    input  logic [`WORD_SIZE-1:0] write_data,
    output logic [`WORD_SIZE-1:0] read_out1,
    output logic [`WORD_SIZE-1:0] read_out2
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[dest] <= write_data;
        end
    end

    // Write-through so ID sees the value MW is writing this cycle
    assign read_out1 = (write_en && dest == read1) ? write_data : regs[read1];
    assign read_out2 = (write_en && dest == read2) ? write_data : regs[read2];

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu (
    input  logic [`WORD_SIZE-1:0] a,
    input  logic [`WORD_SIZE-1:0] b,
    input  isa_pkg::alu_op_t      op,
    output logic [`WORD_SIZE-1:0] result,
    output logic                  not_equal
);

    import isa_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // Branch condition for BNE
    assign not_equal = (a != b);

endmodule

/* logic/pipe_control.sv */
`timescale 1ns/1ps

module pipe_control (
    input  logic clk,
    input  logic reset_n,
    input  logic load_use,
    input  logic redirect,
    input  logic halt_seen,
    output logic stall,
    output logic flush,
    output logic fetch_en
);

    import pipe_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state <= ST_RUN;
        end else begin
            state <= next_state;
        end
    end

    // Halt wins over redirect, redirect over load-use
    always_comb begin
        next_state = state;
        stall      = 1'b0;
        flush      = 1'b0;
        fetch_en   = 1'b1;
        case (state)
            ST_RUN, ST_STALL: begin
                if (halt_seen) begin
                    next_state = ST_HALT;
                    flush      = 1'b1;
                    fetch_en   = 1'b0;
                end else if (redirect) begin
                    next_state = ST_RUN;
                    flush      = 1'b1;
                end else if (load_use && state == ST_RUN) begin
                    next_state = ST_STALL;
                    stall      = 1'b1;
                end else begin
                    next_state = ST_RUN;
                end
            end
            ST_HALT: begin
                // Keep younger slots empty until reset
                flush    = 1'b1;
                fetch_en = 1'b0;
            end
            default: next_state = ST_RUN;
        endcase
    end

endmodule

/* logic/retire_counter.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module retire_counter (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  retire,
    output logic [`WORD_SIZE-1:0] count
);

    // Wraps at the word size
    always_ff @(posedge clk) begin
        if (reset_n) begin
            count <= '0;
        end else if (retire) begin
            count <= count + `WORD_SIZE'(1);
        end
    end

endmodule

/* logic/cpu.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu (
    input  logic                  clk,
    input  logic                  reset_n,
    output logic                  read_m1,
    output logic [`WORD_SIZE-1:0] address1,
    input  logic [`WORD_SIZE-1:0] data1,
    output logic                  read_m2,
    output logic                  write_m2,
    output logic [`WORD_SIZE-1:0] address2,
    input  logic [`WORD_SIZE-1:0] data2,
    output logic [`WORD_SIZE-1:0] wdata2,
    output logic [`WORD_SIZE-1:0] num_inst,
    output logic [`WORD_SIZE-1:0] output_port,
    output logic                  is_halted
);

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam logic [`WORD_SIZE-1:0] nop_word = {OP_NOP, {(`WORD_SIZE-4){1'b0}}};

    logic stall, flush, fetch_en;
    logic load_use, redirect, halt_seen, retire;

    logic [`WORD_SIZE-1:0] pc;
    logic [`WORD_SIZE-1:0] if_id_instr;
    logic [`WORD_SIZE-1:0] if_id_pc_next;

    opcode_t               id_op;
    alu_op_t               id_alu_op;
    logic [`REG_SEL-1:0]   id_rs, id_rt, id_rd, id_dest;
    logic [`WORD_SIZE-1:0] id_rs_val, id_rt_val, id_imm;
    logic                  id_use_imm, id_reg_write, id_uses_rs, id_uses_rt;

    opcode_t               ex_op;
    alu_op_t               ex_alu_op;
    logic                  ex_use_imm, ex_reg_write;
    logic [`REG_SEL-1:0]   ex_rs, ex_rt, ex_dest;
    logic [`WORD_SIZE-1:0] ex_rs_val, ex_rt_val, ex_imm, ex_pc_next;

    fwd_sel_t              fwd_a, fwd_b;
    logic [`WORD_SIZE-1:0] op_a, op_b, alu_b, alu_result, target;
    logic                  not_equal;

    opcode_t               mw_op;
    logic                  mw_reg_write;
    logic [`REG_SEL-1:0]   mw_dest;
    logic [`WORD_SIZE-1:0] mw_result, mw_load, wb_data;

    //////////////////////////////////////////////////////////////////////
    // IF

    assign read_m1  = fetch_en;
    assign address1 = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= '0;
        end else if (fetch_en && !stall) begin
            // Flush with fetch enabled only happens on a redirect
            pc <= flush ? target : pc + `WORD_SIZE'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n || flush) begin
            if_id_instr <= nop_word;
        end else if (!stall) begin
            if_id_instr <= data1;
        end
        if (!stall) begin
            if_id_pc_next <= pc + `WORD_SIZE'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ID

    assign id_op = opcode_t'(if_id_instr[`OPCODE_FIELD]);
    assign id_rs = if_id_instr[`RS_FIELD];
    assign id_rt = if_id_instr[`RT_FIELD];
    assign id_rd = if_id_instr[`RD_FIELD];

    always_comb begin
        id_alu_op    = ALU_PASS_B;
        id_use_imm   = 1'b0;
        id_reg_write = 1'b0;
        id_uses_rs   = 1'b0;
        id_uses_rt   = 1'b0;
        id_dest      = id_rt;
        id_imm = {{(`WORD_SIZE-`IMM8_BITS){if_id_instr[`IMM8_BITS-1]}},
                  if_id_instr[`IMM8_FIELD]};
        case (id_op)
            OP_ADD, OP_SUB: begin
                id_alu_op    = (id_op == OP_ADD) ? ALU_ADD : ALU_SUB;
                id_reg_write = 1'b1;
                id_uses_rs   = 1'b1;
                id_uses_rt   = 1'b1;
                id_dest      = id_rd;
            end
            OP_ADI, OP_LWD: begin
                id_alu_op    = ALU_ADD;
                id_use_imm   = 1'b1;
                id_reg_write = 1'b1;
                id_uses_rs   = 1'b1;
            end
            OP_SWD: begin
                id_alu_op  = ALU_ADD;
                id_use_imm = 1'b1;
                id_uses_rs = 1'b1;
                id_uses_rt = 1'b1;
            end
            OP_BNE: begin
                id_alu_op  = ALU_SUB;
                id_uses_rs = 1'b1;
                id_uses_rt = 1'b1;
            end
            OP_JMP: begin
                // Target goes through the ALU as pass-B
                id_use_imm = 1'b1;
                id_imm = {{(`WORD_SIZE-`IMM12_BITS){1'b0}}, if_id_instr[`IMM12_FIELD]};
            end
            OP_WWD:  id_uses_rs = 1'b1;
            default: ;
        endcase
    end

    register_file register_file_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .read1      (id_rs),
        .read2      (id_rt),
        .write_en   (mw_reg_write),
        .dest       (mw_dest),
        .write_data (wb_data),
        .read_out1  (id_rs_val),
        .read_out2  (id_rt_val)
    );

    assign load_use = (ex_op == OP_LWD) &&
                      ((id_uses_rs && id_rs == ex_rt) || (id_uses_rt && id_rt == ex_rt));

    always_ff @(posedge clk) begin
        if (reset_n || flush || stall) begin
            ex_op        <= OP_NOP;
            ex_reg_write <= 1'b0;
        end else begin
            ex_op        <= id_op;
            ex_reg_write <= id_reg_write;
        end
        ex_alu_op  <= id_alu_op;
        ex_use_imm <= id_use_imm;
        ex_rs      <= id_rs;
        ex_rt      <= id_rt;
        ex_dest    <= id_dest;
        ex_rs_val  <= id_rs_val;
        ex_rt_val  <= id_rt_val;
        ex_imm     <= id_imm;
        ex_pc_next <= if_id_pc_next;
    end

    //////////////////////////////////////////////////////////////////////
    // EX

    assign fwd_a = (mw_reg_write && mw_dest == ex_rs) ? FWD_MW : FWD_REG;
    assign fwd_b = (mw_reg_write && mw_dest == ex_rt) ? FWD_MW : FWD_REG;
    assign op_a  = (fwd_a == FWD_MW) ? wb_data : ex_rs_val;
    assign op_b  = (fwd_b == FWD_MW) ? wb_data : ex_rt_val;
    assign alu_b = ex_use_imm ? ex_imm : op_b;

    alu alu_inst (
        .a         (op_a),
        .b         (alu_b),
        .op        (ex_alu_op),
        .result    (alu_result),
        .not_equal (not_equal)
    );

    assign redirect  = (ex_op == OP_JMP) || (ex_op == OP_BNE && not_equal);
    assign halt_seen = (ex_op == OP_HLT);
    assign target    = (ex_op == OP_JMP) ? alu_result : ex_pc_next + ex_imm;

    // Data port driven straight from EX
    assign read_m2  = (ex_op == OP_LWD);
    assign write_m2 = (ex_op == OP_SWD);
    assign address2 = alu_result;
    assign wdata2   = op_b;

    pipe_control pipe_control_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .load_use  (load_use),
        .redirect  (redirect),
        .halt_seen (halt_seen),
        .stall     (stall),
        .flush     (flush),
        .fetch_en  (fetch_en)
    );

    //////////////////////////////////////////////////////////////////////
    // MW

    always_ff @(posedge clk) begin
        if (reset_n) begin
            mw_op        <= OP_NOP;
            mw_reg_write <= 1'b0;
        end else begin
            mw_op        <= ex_op;
            mw_reg_write <= ex_reg_write;
        end
        mw_dest   <= ex_dest;
        // WWD carries its rs value in the result slot
        mw_result <= (ex_op == OP_WWD) ? op_a : alu_result;
        mw_load   <= data2;
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            is_halted <= 1'b0;
        end else if (mw_op == OP_HLT) begin
            is_halted <= 1'b1;
        end
    end

    assign wb_data     = (mw_op == OP_LWD) ? mw_load : mw_result;
    assign output_port = (mw_op == OP_WWD) ? mw_result : '0;
    assign retire      = (mw_op != OP_NOP);

    retire_counter retire_counter_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .retire  (retire),
        .count   (num_inst)
    );

endmodule

/* verif/cpu_assertions.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_assertions (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  read_m1,
    input logic                  read_m2,
    input logic                  write_m2,
    input logic                  is_halted,
    input logic [`WORD_SIZE-1:0] num_inst,
    input isa_pkg::opcode_t      ex_op
);

    import isa_pkg::*;

    // Data port does one thing per cycle
    assert property (@(posedge clk) disable iff (reset_n) !(read_m2 && write_m2))
        else $error("read_m2 and write_m2 high in the same cycle");

    assert property (@(posedge clk) disable iff (reset_n) is_halted |=> is_halted)
        else $error("is_halted dropped without reset");

    assert property (@(posedge clk) disable iff (reset_n) is_halted |-> !read_m1)
        else $error("read_m1 high while halted");

    assert property (@(posedge clk) disable iff (reset_n) is_halted |-> ex_op == OP_NOP)
        else $error("instruction in EX while halted");

    assert property (@(posedge clk) disable iff (reset_n)
                     !$stable(num_inst) |-> num_inst == $past(num_inst) + `WORD_SIZE'(1))
        else $error("num_inst changed by other than one");

endmodule

bind cpu cpu_assertions cpu_assertions_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .read_m1   (read_m1),
    .read_m2   (read_m2),
    .write_m2  (write_m2),
    .is_halted (is_halted),
    .num_inst  (num_inst),
    .ex_op     (ex_op)
);

/* verif/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb;

    import isa_pkg::*;

    localparam int num_progs   = 4;
    localparam int prog_words  = 16;
    localparam int data_base   = 'h40;
    localparam int cycle_limit = num_progs * 64;

    logic                  clk;
    logic                  reset_n;
    logic                  read_m1;
    logic [`WORD_SIZE-1:0] address1;
    logic [`WORD_SIZE-1:0] data1;
    logic                  read_m2;
    logic                  write_m2;
    logic [`WORD_SIZE-1:0] address2;
    logic [`WORD_SIZE-1:0] data2;
    logic [`WORD_SIZE-1:0] wdata2;
    logic [`WORD_SIZE-1:0] num_inst;
    logic [`WORD_SIZE-1:0] output_port;
    logic                  is_halted;

    // Shared instruction and data memory
    logic [`WORD_SIZE-1:0] mem [256];
    logic                  wr_en;
    logic [7:0]            wr_addr;
    logic [`WORD_SIZE-1:0] wr_data;

    // Zero ends the list of expected WWD values
    logic [`WORD_SIZE-1:0] prog      [num_progs][prog_words];
    logic [`WORD_SIZE-1:0] init_data [num_progs][4];
    logic [`WORD_SIZE-1:0] exp_out   [num_progs][4];
    logic [`WORD_SIZE-1:0] exp_count [num_progs];
    logic [7:0]            exp_addr  [num_progs];
    logic [`WORD_SIZE-1:0] exp_word  [num_progs];

    integer seed;
    int     cycles = 0;

    cpu cpu_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .read_m2     (read_m2),
        .write_m2    (write_m2),
        .address2    (address2),
        .data2       (data2),
        .wdata2      (wdata2),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Memory model

    always @(negedge clk) begin
        data1   = mem[address1[7:0]];
        data2   = read_m2 ? mem[address2[7:0]] : '0;
        wr_en   = write_m2;
        wr_addr = address2[7:0];
        wr_data = wdata2;
    end

    always @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] = wr_data;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: core did not finish the programs within %0d cycles", cycle_limit);
            stop_on_error();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Encoders and checks

    function automatic logic [`WORD_SIZE-1:0] rr_instr(opcode_t op, int rs, int rt, int rd);
        return {op, `REG_SEL'(rs), `REG_SEL'(rt), `REG_SEL'(rd), 6'b000000};
    endfunction

    function automatic logic [`WORD_SIZE-1:0] ri_instr(opcode_t op, int rs, int rt,
                                                       logic [7:0] imm);
        return {op, `REG_SEL'(rs), `REG_SEL'(rt), imm};
    endfunction

    function automatic logic [`WORD_SIZE-1:0] jmp_instr(logic [11:0] target);
        return {OP_JMP, target};
    endfunction

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [`WORD_SIZE-1:0] got,
                              input logic [`WORD_SIZE-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s got %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s got %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program table

    task automatic build_table();
        for (int p = 0; p < num_progs; p++) begin
            for (int i = 0; i < prog_words; i++) begin
                prog[p][i] = ri_instr(OP_NOP, 0, 0, 8'h00);
            end
        end
        // Dependent chain, MW forwarding and register bypass
        prog[0][0] = ri_instr(OP_ADI, 0, 1, 8'h05);
        prog[0][1] = ri_instr(OP_ADI, 1, 2, 8'h03);
        prog[0][2] = rr_instr(OP_ADD, 1, 2, 3);
        prog[0][3] = rr_instr(OP_SUB, 3, 1, 1);
        prog[0][4] = ri_instr(OP_WWD, 1, 0, 8'h00);
        prog[0][5] = ri_instr(OP_WWD, 3, 0, 8'h00);
        prog[0][6] = ri_instr(OP_ADI, 2, 2, 8'hFF);
        prog[0][7] = ri_instr(OP_WWD, 2, 0, 8'h00);
        prog[0][8] = ri_instr(OP_HLT, 0, 0, 8'h00);
        init_data[0] = '{16'h0011, 16'h0022, 16'h0033, 16'h0044};
        exp_out[0]   = '{16'h0008, 16'h000D, 16'h0007, 16'h0000};
        exp_count[0] = 16'd9;
        exp_addr[0]  = 8'h40;
        exp_word[0]  = 16'h0011;
        // Store, load back, load-use stalls
        prog[1][0] = ri_instr(OP_ADI, 0, 1, 8'h40);
        prog[1][1] = ri_instr(OP_LWD, 1, 2, 8'h00);
        prog[1][2] = rr_instr(OP_ADD, 2, 2, 3);
        prog[1][3] = ri_instr(OP_SWD, 1, 3, 8'h02);
        prog[1][4] = ri_instr(OP_LWD, 1, 0, 8'h02);
        prog[1][5] = rr_instr(OP_SUB, 0, 2, 3);
        prog[1][6] = ri_instr(OP_WWD, 3, 0, 8'h00);
        prog[1][7] = ri_instr(OP_WWD, 0, 0, 8'h00);
        prog[1][8] = ri_instr(OP_HLT, 0, 0, 8'h00);
        init_data[1] = '{16'h0011, 16'h1234, 16'h5555, 16'h7777};
        exp_out[1]   = '{16'h0011, 16'h0022, 16'h0000, 16'h0000};
        exp_count[1] = 16'd9;
        exp_addr[1]  = 8'h42;
        exp_word[1]  = 16'h0022;
        // r3 holds a marker that only the flushed slots print
        prog[2][0]  = ri_instr(OP_ADI, 0, 3, 8'h77);
        prog[2][1]  = ri_instr(OP_ADI, 0, 1, 8'h01);
        prog[2][2]  = ri_instr(OP_BNE, 1, 0, 8'h02);
        prog[2][3]  = ri_instr(OP_WWD, 3, 0, 8'h00);
        prog[2][4]  = ri_instr(OP_WWD, 3, 0, 8'h00);
        prog[2][5]  = ri_instr(OP_WWD, 1, 0, 8'h00);
        prog[2][6]  = ri_instr(OP_BNE, 1, 1, 8'h05);
        prog[2][7]  = ri_instr(OP_ADI, 1, 2, 8'h02);
        prog[2][8]  = jmp_instr(12'd11);
        prog[2][9]  = ri_instr(OP_WWD, 3, 0, 8'h00);
        prog[2][10] = ri_instr(OP_WWD, 3, 0, 8'h00);
        prog[2][11] = ri_instr(OP_WWD, 2, 0, 8'h00);
        prog[2][12] = ri_instr(OP_HLT, 0, 0, 8'h00);
        init_data[2] = '{16'h0A0A, 16'h0B0B, 16'h0C0C, 16'h0D0D};
        exp_out[2]   = '{16'h0001, 16'h0003, 16'h0000, 16'h0000};
        exp_count[2] = 16'd9;
        exp_addr[2]  = 8'h41;
        exp_word[2]  = 16'h0B0B;
        // Nothing after HLT may retire
        prog[3][0] = ri_instr(OP_ADI, 0, 1, 8'h09);
        prog[3][1] = ri_instr(OP_WWD, 1, 0, 8'h00);
        prog[3][2] = ri_instr(OP_HLT, 0, 0, 8'h00);
        prog[3][3] = ri_instr(OP_ADI, 0, 2, 8'h55);
        prog[3][4] = ri_instr(OP_WWD, 2, 0, 8'h00);
        prog[3][5] = ri_instr(OP_WWD, 1, 0, 8'h00);
        init_data[3] = '{16'h1111, 16'h2222, 16'h3333, 16'h4444};
        exp_out[3]   = '{16'h0009, 16'h0000, 16'h0000, 16'h0000};
        exp_count[3] = 16'd3;
        exp_addr[3]  = 8'h43;
        exp_word[3]  = 16'h4444;
    endtask

    task automatic run_program(input int p);
        int seen;
        seen = 0;
        for (int a = 0; a < 256; a++) begin
            if (a < prog_words) begin
                mem[a] = prog[p][a];
            end else if (a >= data_base && a < data_base + 4) begin
                mem[a] = init_data[p][a - data_base];
            end else begin
                mem[a] = `WORD_SIZE'($random(seed));
            end
        end
        @(negedge clk);
        reset_n = 1'b1;
        repeat (5) @(negedge clk);
        reset_n = 1'b0;
        check_word("address1", address1, '0);
        check_flag("read_m1", read_m1, 1'b1);
        check_flag("read_m2", read_m2, 1'b0);
        check_flag("write_m2", write_m2, 1'b0);
        check_flag("is_halted", is_halted, 1'b0);
        check_word("num_inst", num_inst, '0);
        check_word("output_port", output_port, '0);
        while (!is_halted) begin
            if (output_port != '0) begin
                if (seen >= 4 || exp_out[p][seen] == '0) begin
                    $display("Program %0d printed an extra value %h", p, output_port);
                    stop_on_error();
                end
                check_word("output_port", output_port, exp_out[p][seen]);
                seen++;
            end
            @(negedge clk);
        end
        if (seen < 4 && exp_out[p][seen] != '0) begin
            $display("Program %0d halted after only %0d WWD values", p, seen);
            stop_on_error();
        end
        // Core must stay parked
        repeat (4) begin
            @(negedge clk);
            check_flag("is_halted", is_halted, 1'b1);
            check_flag("read_m1", read_m1, 1'b0);
            check_word("output_port", output_port, '0);
        end
        check_word("num_inst", num_inst, exp_count[p]);
        check_word($sformatf("mem[%02h]", exp_addr[p]), mem[exp_addr[p]], exp_word[p]);
    endtask

    initial begin
        clk     = 1'b0;
        reset_n = 1'b1;
        data1   = '0;
        data2   = '0;
        wr_en   = 1'b0;
        seed    = 32'h5d68ba60;
        build_table();
        for (int p = 0; p < num_progs; p++) begin
            run_program(p);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/pipe_control.sv
logic/retire_counter.sv
logic/cpu.sv
verif/cpu_assertions.sv
verif/cpu_tb.sv

/* Makefile */
# Verilator simulation of the pipelined CPU

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= src.f
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Simulation failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
